// File: list.f
common/dcache_pkg.sv
common/dcache_fill_if.sv
src/replay_fifo.sv
dcache/dcache_pipe.sv
dcache/miss_engine.sv
src/trace_wrapper.sv
verification/mem_model.sv
verification/trace_tb.sv

// File: Bender.yml
package:
  name: trace_dcache

sources:
  - common/dcache_pkg.sv
  - common/dcache_fill_if.sv
  - src/replay_fifo.sv
  - dcache/dcache_pipe.sv
  - dcache/miss_engine.sv
  - src/trace_wrapper.sv
  - target: simulation
    files:
      - verification/mem_model.sv
      - verification/trace_tb.sv

// File: verification/trace_tb.sv
`default_nettype none

module trace_tb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int random_ops = 200;
   localparam int num_ops = 8 + 5 + random_ops;
   localparam int cycle_limit = 40 * num_ops;

   logic clk_i;
   logic rst_i;
   logic pkt_v_i;
   dcache_pkg::dcache_pkt_t pkt_i;
   dcache_pkg::ptag_t ptag_i;
   logic ready_o;
   dcache_pkg::dword_t data_o;
   logic v_o;
   logic mem_cmd_v_o;
   logic mem_cmd_write_o;
   dcache_pkg::paddr_t mem_cmd_addr_o;
   dcache_pkg::dword_t mem_cmd_data_o;
   logic mem_cmd_ready_i;
   logic mem_resp_v_i;
   dcache_pkg::dword_t mem_resp_data_i;
   logic mem_resp_yumi_o;

   dcache_pkg::dword_t ref_mem [dcache_pkg::paddr_t];
   dcache_pkg::dword_t exp_q [$];
   dcache_pkg::paddr_t wr_addr_q [$];
   dcache_pkg::dword_t wr_data_q [$];
   int accepted_count;
   int result_count;
   int cycle_count;

   trace_wrapper #(.sets_p(8), .fifo_els_p(8)) u_trace_wrapper (.*);

   mem_model u_mem_model
   (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .cmd_v_i     (mem_cmd_v_o),
      .cmd_write_i (mem_cmd_write_o),
      .cmd_addr_i  (mem_cmd_addr_o),
      .cmd_data_i  (mem_cmd_data_o),
      .cmd_ready_o (mem_cmd_ready_i),
      .resp_v_o    (mem_resp_v_i),
      .resp_data_o (mem_resp_data_i),
      .resp_yumi_i (mem_resp_yumi_o)
   );

   always #5 clk_i = ~clk_i;

   task automatic report_failure(input string what);
      $display("%s", what);
      $display("Test failures found");
      $fatal(1);
   endtask

   task automatic verify_flag(input string name, input logic got, input logic exp);
      if (got !== exp)
         report_failure($sformatf("** Error: %s expected %h got %h", name, exp, got));
   endtask

   task automatic check_data(input dcache_pkg::dword_t got, input dcache_pkg::dword_t exp);
      if (got !== exp)
         report_failure($sformatf("** Error: data_o expected %h got %h", exp, got));
   endtask

   task automatic check_mem_write(input dcache_pkg::paddr_t got_addr,
      input dcache_pkg::dword_t got_data, input dcache_pkg::paddr_t exp_addr,
      input dcache_pkg::dword_t exp_data);
      if (got_addr !== exp_addr)
         report_failure($sformatf("** Error: mem_cmd_addr_o expected %h got %h",
            exp_addr, got_addr));
      if (got_data !== exp_data)
         report_failure($sformatf("** Error: mem_cmd_data_o expected %h got %h",
            exp_data, got_data));
   endtask

   function automatic dcache_pkg::dword_t init_word(input dcache_pkg::paddr_t addr);
      return {4'ha, addr, ~addr, addr ^ 20'h5c3e7};
   endfunction

   // Loads see the latest store in trace order and stores return zero
   function automatic dcache_pkg::dword_t expected_result(input dcache_pkg::opcode_e op,
      input dcache_pkg::paddr_t addr, input dcache_pkg::dword_t data);
      if (op == dcache_pkg::e_op_store)
      begin
         ref_mem[addr] = data;
         return '0;
      end
      if (ref_mem.exists(addr))
         return ref_mem[addr];
      return init_word(addr);
   endfunction

   // 32 dword addresses with four tags per set
   function automatic dcache_pkg::paddr_t pick_addr(input int k);
      return {8'h40 + 8'(k >> 3), 6'h0, 3'(k), 3'b000};
   endfunction

   task automatic send_op(input dcache_pkg::opcode_e op, input dcache_pkg::paddr_t addr,
      input dcache_pkg::dword_t data);
      pkt_v_i <= 1'b1;
      pkt_i <= {op, addr[11:0], data};
      ptag_i <= addr[19:12];
      @(posedge clk_i);
      while (!ready_o)
         @(posedge clk_i);
      exp_q.push_back(expected_result(op, addr, data));
      if (op == dcache_pkg::e_op_store)
      begin
         wr_addr_q.push_back(addr);
         wr_data_q.push_back(data);
      end
      accepted_count++;
   endtask

   always @(posedge clk_i)
   begin
      if (!rst_i && v_o)
      begin
         if (exp_q.size() == 0)
            report_failure("A result came out with no operation outstanding");
         else
            check_data(data_o, exp_q.pop_front());
         result_count++;
      end
   end

   always @(posedge clk_i)
   begin
      if (!rst_i && mem_cmd_v_o && mem_cmd_ready_i && mem_cmd_write_o)
      begin
         if (wr_addr_q.size() == 0)
            report_failure("A memory write was issued with no store outstanding");
         else
            check_mem_write(mem_cmd_addr_o, mem_cmd_data_o, wr_addr_q.pop_front(),
               wr_data_q.pop_front());
      end
   end

   always @(posedge clk_i)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit)
         report_failure("Timeout, the run did not finish within the cycle limit");
   end

   initial
   begin
      dcache_pkg::opcode_e op;
      int k;
      void'($urandom(76211));
      clk_i = 1'b0;
      rst_i = 1'b1;
      pkt_v_i = 1'b0;
      pkt_i = '0;
      ptag_i = '0;
      accepted_count = 0;
      result_count = 0;
      cycle_count = 0;
      repeat (3) @(posedge clk_i);
      rst_i <= 1'b0;

      // Quiet outputs before any traffic
      repeat (5)
      begin
         @(posedge clk_i);
         verify_flag("v_o", v_o, 1'b0);
         verify_flag("mem_cmd_v_o", mem_cmd_v_o, 1'b0);
         verify_flag("mem_resp_yumi_o", mem_resp_yumi_o, 1'b0);
         verify_flag("ready_o", ready_o, 1'b1);
      end

      // Cold loads to every set
      for (int i = 0; i < 8; i++)
         send_op(dcache_pkg::e_op_load, pick_addr(i), '0);

      // Store hit and store miss to an aliasing tag followed by reloads
      send_op(dcache_pkg::e_op_store, pick_addr(2), 64'hdead_beef_0000_0002);
      send_op(dcache_pkg::e_op_load, pick_addr(2), '0);
      send_op(dcache_pkg::e_op_store, pick_addr(10), 64'hdead_beef_0000_000a);
      send_op(dcache_pkg::e_op_load, pick_addr(10), '0);
      send_op(dcache_pkg::e_op_load, pick_addr(2), '0);

      for (int i = 0; i < random_ops; i++)
      begin
         op = ($urandom % 2) ? dcache_pkg::e_op_store : dcache_pkg::e_op_load;
         k = $urandom % 32;
         send_op(op, pick_addr(k), {$urandom, $urandom});
      end
      pkt_v_i <= 1'b0;

      while (result_count != accepted_count || wr_addr_q.size() != 0)
         @(posedge clk_i);
      // Idle cycles would expose duplicated results
      repeat (20) @(posedge clk_i);

      $display("All tests passed!");
      $finish;
   end

endmodule

`default_nettype wire

// File: verification/mem_model.sv
`default_nettype none

module mem_model
(
   input  wire logic               clk_i,
   input  wire logic               rst_i,

   input  wire logic               cmd_v_i,
   input  wire logic               cmd_write_i,
   input  wire dcache_pkg::paddr_t cmd_addr_i,
   input  wire dcache_pkg::dword_t cmd_data_i,
   output logic                    cmd_ready_o,

   output logic                    resp_v_o,
   output dcache_pkg::dword_t      resp_data_o,
   input  wire logic               resp_yumi_i
);

   timeunit 1ns;
   timeprecision 1ps;

   // Sparse storage, untouched words read back as a hash of the address
   dcache_pkg::dword_t mem [dcache_pkg::paddr_t];

   logic pending_r;
   logic [1:0] delay_r;

   function automatic dcache_pkg::dword_t init_word(input dcache_pkg::paddr_t addr);
      return {4'ha, addr, ~addr, addr ^ 20'h5c3e7};
   endfunction

   function automatic dcache_pkg::dword_t read_word(input dcache_pkg::paddr_t addr);
      if (mem.exists(addr))
         return mem[addr];
      return init_word(addr);
   endfunction

   initial
   begin
      cmd_ready_o = 1'b0;
      resp_v_o = 1'b0;
      resp_data_o = '0;
      pending_r = 1'b0;
      delay_r = '0;
   end

   always @(posedge clk_i)
   begin
      if (rst_i)
      begin
         cmd_ready_o <= 1'b0;
         resp_v_o <= 1'b0;
         pending_r <= 1'b0;
         delay_r <= '0;
      end
      else
      begin
         // Random back-pressure, ready about three cycles in four
         cmd_ready_o <= ($urandom % 4) != 0;
         if (cmd_v_i && cmd_ready_o)
         begin
            if (cmd_write_i)
               mem[cmd_addr_i] = cmd_data_i;
            else
            begin
               pending_r <= 1'b1;
               delay_r <= 2'($urandom % 4);
               resp_data_o <= read_word(cmd_addr_i);
            end
         end
         if (resp_v_o && resp_yumi_i)
            resp_v_o <= 1'b0;
         if (pending_r)
         begin
            if (delay_r == 0)
            begin
               resp_v_o <= 1'b1;
               pending_r <= 1'b0;
            end
            else
               delay_r <= delay_r - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: src/trace_wrapper.sv
`default_nettype none

module trace_wrapper
#(
   parameter int sets_p = 8,
   parameter int fifo_els_p = 8
)
(
   input  wire logic                    clk_i,
   input  wire logic                    rst_i,

   input  wire logic                    pkt_v_i,
   input  wire dcache_pkg::dcache_pkt_t pkt_i,
   input  wire dcache_pkg::ptag_t       ptag_i,
   output logic                         ready_o,

   output dcache_pkg::dword_t           data_o,
   output logic                         v_o,

   output logic                         mem_cmd_v_o,
   output logic                         mem_cmd_write_o,
   output dcache_pkg::paddr_t           mem_cmd_addr_o,
   output dcache_pkg::dword_t           mem_cmd_data_o,
   input  wire logic                    mem_cmd_ready_i,

   input  wire logic                    mem_resp_v_i,
   input  wire dcache_pkg::dword_t      mem_resp_data_i,
   output logic                         mem_resp_yumi_o
);

   // FIFO head toward the pipe
   logic issue_v_lo;
   dcache_pkg::dcache_pkt_t issue_pkt_lo;
   dcache_pkg::ptag_t issue_ptag_lo;
   logic take_lo;
   logic rollback_lo;

   dcache_fill_if #(.sets_p(sets_p)) fill_if ();

   replay_fifo #(
      .fifo_els_p(fifo_els_p)
   ) u_replay_fifo (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .enq_v_i      (pkt_v_i),
      .enq_pkt_i    (pkt_i),
      .enq_ptag_i   (ptag_i),
      .ready_o      (ready_o),
      .issue_v_o    (issue_v_lo),
      .issue_pkt_o  (issue_pkt_lo),
      .issue_ptag_o (issue_ptag_lo),
      .take_i       (take_lo),
      .commit_i     (v_o),
      .rollback_i   (rollback_lo)
   );

   dcache_pipe #(
      .sets_p(sets_p)
   ) u_dcache_pipe (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .issue_v_i    (issue_v_lo),
      .issue_pkt_i  (issue_pkt_lo),
      .issue_ptag_i (issue_ptag_lo),
      .take_o       (take_lo),
      .commit_o     (v_o),
      .rollback_o   (rollback_lo),
      .data_o       (data_o),
      .fill         (fill_if.cache)
   );

   miss_engine #(
      .sets_p(sets_p)
   ) u_miss_engine (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .fill            (fill_if.engine),
      .mem_cmd_v_o     (mem_cmd_v_o),
      .mem_cmd_write_o (mem_cmd_write_o),
      .mem_cmd_addr_o  (mem_cmd_addr_o),
      .mem_cmd_data_o  (mem_cmd_data_o),
      .mem_cmd_ready_i (mem_cmd_ready_i),
      .mem_resp_v_i    (mem_resp_v_i),
      .mem_resp_data_i (mem_resp_data_i),
      .mem_resp_yumi_o (mem_resp_yumi_o)
   );

endmodule

`default_nettype wire

// File: dcache/miss_engine.sv
`default_nettype none

module miss_engine
#(
   parameter int sets_p = 8
)
(
   input  wire logic               clk_i,
   input  wire logic               rst_i,

   dcache_fill_if.engine           fill,

   output logic                    mem_cmd_v_o,
   output logic                    mem_cmd_write_o,
   output dcache_pkg::paddr_t      mem_cmd_addr_o,
   output dcache_pkg::dword_t      mem_cmd_data_o,
   input  wire logic               mem_cmd_ready_i,

   input  wire logic               mem_resp_v_i,
   input  wire dcache_pkg::dword_t mem_resp_data_i,
   output logic                    mem_resp_yumi_o
);

   localparam int index_width_lp = $clog2(sets_p);
   localparam int tag_width_lp =
      dcache_pkg::paddr_width - dcache_pkg::block_offset_width - index_width_lp;

   dcache_pkg::engine_state_e state_r;
   dcache_pkg::engine_state_e state_n;
   dcache_pkg::paddr_t addr_r;
   dcache_pkg::dword_t data_r;
   dcache_pkg::dword_t fill_data_r;
   logic fill_v_r;

   // The fill cycle counts as busy so no store update races it
   assign fill.busy = (state_r != dcache_pkg::e_idle) | fill_v_r;
   assign fill.fill_v = fill_v_r;
   assign fill.fill_index = addr_r[dcache_pkg::block_offset_width +: index_width_lp];
   assign fill.fill_tag = addr_r[dcache_pkg::paddr_width-1 -: tag_width_lp];
   assign fill.fill_data = fill_data_r;

   assign mem_cmd_v_o = (state_r == dcache_pkg::e_send_read)
      | (state_r == dcache_pkg::e_send_write);
   assign mem_cmd_write_o = (state_r == dcache_pkg::e_send_write);
   assign mem_cmd_addr_o = addr_r;
   assign mem_cmd_data_o = data_r;
   assign mem_resp_yumi_o = (state_r == dcache_pkg::e_wait_resp) & mem_resp_v_i;

   always_comb
   begin
      state_n = state_r;
      case (state_r)
         dcache_pkg::e_idle:
         begin
            // Miss first, the pipe never raises both at once
            if (!fill.busy && fill.miss_v)
               state_n = dcache_pkg::e_send_read;
            else if (!fill.busy && fill.store_v)
               state_n = dcache_pkg::e_send_write;
         end
         dcache_pkg::e_send_read:
            if (mem_cmd_ready_i)
               state_n = dcache_pkg::e_wait_resp;
         dcache_pkg::e_wait_resp:
            if (mem_resp_v_i)
               state_n = dcache_pkg::e_idle;
         dcache_pkg::e_send_write:
            if (mem_cmd_ready_i)
               state_n = dcache_pkg::e_idle;
         default:
            state_n = dcache_pkg::e_idle;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         state_r <= dcache_pkg::e_idle;
         fill_v_r <= 1'b0;
      end
      else
      begin
         state_r <= state_n;
         fill_v_r <= mem_resp_yumi_o;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (state_r == dcache_pkg::e_idle && !fill.busy)
      begin
         if (fill.miss_v)
            addr_r <= fill.miss_addr;
         else if (fill.store_v)
         begin
            addr_r <= fill.store_addr;
            data_r <= fill.store_data;
         end
      end
      if (mem_resp_yumi_o)
         fill_data_r <= mem_resp_data_i;
   end

   cmd_held_a: assert property (@(posedge clk_i) disable iff (rst_i)
      mem_cmd_v_o && !mem_cmd_ready_i |=>
         mem_cmd_v_o && $stable(mem_cmd_addr_o) && $stable(mem_cmd_write_o))
      else $error("miss_engine: command dropped before acceptance");

endmodule

`default_nettype wire

// File: dcache/dcache_pipe.sv
`default_nettype none

module dcache_pipe
#(
   parameter int sets_p = 8
)
(
   input  wire logic                    clk_i,
   input  wire logic                    rst_i,

   input  wire logic                    issue_v_i,
   input  wire dcache_pkg::dcache_pkt_t issue_pkt_i,
   input  wire dcache_pkg::ptag_t       issue_ptag_i,
   output logic                         take_o,
   output logic                         commit_o,
   output logic                         rollback_o,
   output dcache_pkg::dword_t           data_o,

   dcache_fill_if.cache                 fill
);

   localparam int index_width_lp = $clog2(sets_p);
   localparam int tag_width_lp =
      dcache_pkg::paddr_width - dcache_pkg::block_offset_width - index_width_lp;

   typedef logic [index_width_lp-1:0] index_t;
   typedef logic [tag_width_lp-1:0] tag_t;

   tag_t tag_mem [sets_p];
   dcache_pkg::dword_t data_mem [sets_p];
   logic [sets_p-1:0] valid_r;

   logic s1_v_r;
   dcache_pkg::dcache_pkt_t s1_pkt_r;
   dcache_pkg::ptag_t s1_ptag_r;
   dcache_pkg::paddr_t s1_addr;
   index_t s1_index;
   logic s1_fill_match;
   logic s1_store_match;

   logic s2_v_r;
   logic s2_store_r;
   dcache_pkg::paddr_t s2_addr_r;
   dcache_pkg::dword_t s2_data_r;
   logic s2_line_v_r;
   tag_t s2_tag_r;
   dcache_pkg::dword_t s2_line_r;
   index_t s2_index;
   logic s2_hit;

   logic commit;
   logic poison;
   logic store_hit;
   logic load_miss;
   logic miss_pending_r;
   dcache_pkg::paddr_t miss_addr_r;

   assign s1_addr = {s1_ptag_r,
      s1_pkt_r[dcache_pkg::pkt_offset_lsb +: dcache_pkg::page_offset_width]};
   assign s1_index = s1_addr[dcache_pkg::block_offset_width +: index_width_lp];

   assign s2_index = s2_addr_r[dcache_pkg::block_offset_width +: index_width_lp];
   assign s2_hit = s2_line_v_r
      && (s2_tag_r == s2_addr_r[dcache_pkg::paddr_width-1 -: tag_width_lp]);

   // Stores go through to memory, so they need a free engine
   assign commit = s2_v_r & (s2_store_r ? ~fill.busy : s2_hit);
   assign poison = s2_v_r & ~commit;
   assign store_hit = commit & s2_store_r & s2_hit;
   assign load_miss = s2_v_r & ~s2_store_r & ~s2_hit;

   assign take_o = issue_v_i & ~poison;
   assign commit_o = commit;
   assign rollback_o = poison;
   assign data_o = s2_store_r ? '0 : s2_line_r;

   // Writes landing this cycle are forwarded into the stage 1 read
   assign s1_fill_match = fill.fill_v && (fill.fill_index == s1_index);
   assign s1_store_match = store_hit && (s2_index == s1_index);

   assign fill.miss_v = miss_pending_r;
   assign fill.miss_addr = miss_addr_r;
   assign fill.store_v = commit & s2_store_r;
   assign fill.store_addr = s2_addr_r;
   assign fill.store_data = s2_data_r;

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         s1_v_r <= 1'b0;
         s2_v_r <= 1'b0;
         miss_pending_r <= 1'b0;
      end
      else
      begin
         s1_v_r <= take_o;
         s2_v_r <= s1_v_r & ~poison;
         if (load_miss && !fill.busy && !miss_pending_r)
            miss_pending_r <= 1'b1;
         else if (!fill.busy)
            miss_pending_r <= 1'b0;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (take_o)
      begin
         s1_pkt_r <= issue_pkt_i;
         s1_ptag_r <= issue_ptag_i;
      end
      if (load_miss && !fill.busy && !miss_pending_r)
         miss_addr_r <= s2_addr_r;

      s2_store_r <= dcache_pkg::opcode_e'(
         s1_pkt_r[dcache_pkg::pkt_opcode_lsb +: $bits(dcache_pkg::opcode_e)])
         == dcache_pkg::e_op_store;
      s2_addr_r <= s1_addr;
      s2_data_r <= s1_pkt_r[dcache_pkg::pkt_data_lsb +: dcache_pkg::dword_width];
      s2_tag_r <= s1_fill_match ? fill.fill_tag : tag_mem[s1_index];
      s2_line_v_r <= s1_fill_match | valid_r[s1_index];
      if (s1_fill_match)
         s2_line_r <= fill.fill_data;
      else if (s1_store_match)
         s2_line_r <= s2_data_r;
      else
         s2_line_r <= data_mem[s1_index];
   end

   always_ff @(posedge clk_i)
   begin
      if (fill.fill_v)
      begin
         tag_mem[fill.fill_index] <= fill.fill_tag;
         data_mem[fill.fill_index] <= fill.fill_data;
      end
      else if (store_hit)
         data_mem[s2_index] <= s2_data_r;
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         valid_r <= '0;
      else if (fill.fill_v)
         valid_r[fill.fill_index] <= 1'b1;
   end

   // Engine keeps busy high through its fill write
   fill_store_excl_a: assert property (@(posedge clk_i) disable iff (rst_i)
      !(fill.fill_v && fill.store_v))
      else $error("dcache_pipe: store commit during a fill write");

endmodule

`default_nettype wire

// File: src/replay_fifo.sv
`default_nettype none

module replay_fifo
#(
   parameter int fifo_els_p = 8
)
(
   input  wire logic                    clk_i,
   input  wire logic                    rst_i,

   input  wire logic                    enq_v_i,
   input  wire dcache_pkg::dcache_pkt_t enq_pkt_i,
   input  wire dcache_pkg::ptag_t       enq_ptag_i,
   output logic                         ready_o,

   output logic                         issue_v_o,
   output dcache_pkg::dcache_pkt_t      issue_pkt_o,
   output dcache_pkg::ptag_t            issue_ptag_o,

   input  wire logic                    take_i,
   input  wire logic                    commit_i,
   input  wire logic                    rollback_i
);

   localparam int addr_width_lp = $clog2(fifo_els_p);

   // Extra top bit tells full from empty
   typedef logic [addr_width_lp:0] ptr_t;

   dcache_pkg::dcache_pkt_t pkt_mem [fifo_els_p];
   dcache_pkg::ptag_t ptag_mem [fifo_els_p];

   ptr_t wptr_r;
   ptr_t iptr_r;
   ptr_t cptr_r;
   logic full;
   logic enq;

   // Space is only freed by commits, replays stay intact
   assign full = (wptr_r[addr_width_lp] != cptr_r[addr_width_lp])
      && (wptr_r[addr_width_lp-1:0] == cptr_r[addr_width_lp-1:0]);
   assign ready_o = ~full;
   assign enq = enq_v_i & ~full;

   assign issue_v_o = (iptr_r != wptr_r);
   assign issue_pkt_o = pkt_mem[iptr_r[addr_width_lp-1:0]];
   assign issue_ptag_o = ptag_mem[iptr_r[addr_width_lp-1:0]];

   always_ff @(posedge clk_i)
   begin
      if (enq)
      begin
         pkt_mem[wptr_r[addr_width_lp-1:0]] <= enq_pkt_i;
         ptag_mem[wptr_r[addr_width_lp-1:0]] <= enq_ptag_i;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         wptr_r <= '0;
         iptr_r <= '0;
         cptr_r <= '0;
      end
      else
      begin
         if (enq)
            wptr_r <= wptr_r + 1'b1;
         // Poisoned ops are offered again from the oldest uncommitted one
         if (rollback_i)
            iptr_r <= cptr_r;
         else if (take_i)
            iptr_r <= iptr_r + 1'b1;
         if (commit_i)
            cptr_r <= cptr_r + 1'b1;
      end
   end

   commit_not_empty_a: assert property (@(posedge clk_i) disable iff (rst_i)
      commit_i |-> (cptr_r != wptr_r))
      else $error("replay_fifo: commit with no uncommitted entry");

endmodule

`default_nettype wire

// File: common/dcache_fill_if.sv
`default_nettype none

interface dcache_fill_if
#(
   parameter int sets_p = 8
);

   localparam int index_width_lp = $clog2(sets_p);
   localparam int tag_width_lp =
      dcache_pkg::paddr_width - dcache_pkg::block_offset_width - index_width_lp;

   // Requests from the cache pipe
   logic miss_v;
   dcache_pkg::paddr_t miss_addr;
   logic store_v;
   dcache_pkg::paddr_t store_addr;
   dcache_pkg::dword_t store_data;

   // Engine status and array writes
   logic busy;
   logic fill_v;
   logic [index_width_lp-1:0] fill_index;
   logic [tag_width_lp-1:0] fill_tag;
   dcache_pkg::dword_t fill_data;

   modport cache
   (
      output miss_v, miss_addr, store_v, store_addr, store_data,
      input  busy, fill_v, fill_index, fill_tag, fill_data
   );

   modport engine
   (
      input  miss_v, miss_addr, store_v, store_addr, store_data,
      output busy, fill_v, fill_index, fill_tag, fill_data
   );

endinterface

`default_nettype wire

// File: common/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

   localparam int dword_width = 64;
   localparam int ptag_width = 8;
   localparam int page_offset_width = 12;
   localparam int paddr_width = ptag_width + page_offset_width;

   // Byte within a dword
   localparam int block_offset_width = 3;

   typedef logic [dword_width-1:0] dword_t;
   typedef logic [ptag_width-1:0] ptag_t;
   typedef logic [page_offset_width-1:0] page_offset_t;
   typedef logic [paddr_width-1:0] paddr_t;

   typedef enum logic [1:0]
   {
      e_op_load  = 2'b00,
      e_op_store = 2'b01
   } opcode_e;

   // Packet layout, opcode on top, then page offset, then store data
   localparam int pkt_data_lsb = 0;
   localparam int pkt_offset_lsb = pkt_data_lsb + dword_width;
   localparam int pkt_opcode_lsb = pkt_offset_lsb + page_offset_width;
   localparam int dcache_pkt_width = pkt_opcode_lsb + $bits(opcode_e);

   typedef logic [dcache_pkt_width-1:0] dcache_pkt_t;

   typedef enum logic [1:0]
   {
      e_idle,
      e_send_read,
      e_wait_resp,
      e_send_write
   } engine_state_e;

endpackage

`default_nettype wire
